/* verilog/mipsPkg.sv */
package mipsPkg;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL funct field
	localparam logic [5:0] FN_MFHI = 6'h10;
	localparam logic [5:0] FN_MFLO = 6'h12;
	localparam logic [5:0] FN_MULT = 6'h18;
	localparam logic [5:0] FN_DIV  = 6'h1a;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	// Same word, two field layouts
	typedef union packed {
		rTypeT r;
		iTypeT i;
	} instrT;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI} aluOpT;
	typedef enum logic [1:0] {MDU_NONE, MDU_MULT, MDU_DIV} mduOpT;

	////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////
	typedef struct packed {
		aluOpT      aluOp;
		logic       immSrc;    // B operand from immediate
		logic       regWrite;
		logic [4:0] dest;
		logic       memWrite;
		logic       memToReg;
		logic       multStart;
		logic       divStart;
		logic       selHi;
		logic       selLo;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
	} idExT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [4:0]  rt;         // Source of store data
		logic [31:0] result;
		logic [31:0] storeData;
	} exMemT;

	typedef struct packed {
		logic [31:0] pc;
		logic        regWrite;
		logic [4:0]  dest;
		logic [31:0] data;
	} memWbT;

	// Nearest producer wins, loads in memory stage have no data yet
	function automatic logic [31:0] forwardOperand(input logic [4:0] regNum,
			input logic [31:0] regVal, input exMemT mem, input memWbT wb);
		if (regNum != 5'd0 && mem.ctrl.regWrite && !mem.ctrl.memToReg &&
				mem.ctrl.dest == regNum)
			return mem.result;
		if (regNum != 5'd0 && wb.regWrite && wb.dest == regNum)
			return wb.data;
		return regVal;
	endfunction

endpackage

/* verilog/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage #(
	parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           stall,
	input  logic           branchTaken,
	input  logic [31:0]    branchTarget,
	input  logic [31:0]    instrIn,
	output logic [31:0]    pc,
	output logic [31:0]    pcD,
	output mipsPkg::instrT instrD
);

	// Program counter
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (!stall) begin
			pc <= branchTaken ? branchTarget : pc + 32'd4;
		end
	end

	// Fetch to decode register, delay slot flows through untouched
	always_ff @(posedge clk) begin
		if (reset) begin
			pcD    <= RESET_PC;
			instrD <= '0;    // Decodes as nop
		end else if (!stall) begin
			pcD    <= pc;
			instrD <= instrIn;
		end
	end

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic           clk,
	input  logic           reset,
	input  logic [31:0]    pcD,
	input  mipsPkg::instrT instrD,
	input  mipsPkg::exMemT exFwd,
	input  mipsPkg::memWbT wbFwd,
	input  mipsPkg::idExT  idExCur,
	input  logic           mduBusy,
	output logic           stall,
	output logic           branchTaken,
	output logic [31:0]    branchTarget,
	output mipsPkg::idExT  idEx
);
	import mipsPkg::*;

	logic [31:0] regFile [32];
	logic        isR, isAddu, isSubu, isMult, isDiv, isMfhi, isMflo;
	logic        isOri, isLui, isLw, isSw, isBeq;
	logic        usesRt;
	logic [31:0] signImm;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	ctrlT        ctrl;
	logic        loadUse;
	logic        mduHazard;
	logic        branchHazard;

	function automatic logic hitsSource(input logic [4:0] dest, input logic [4:0] rs,
			input logic [4:0] rt);
		return dest != 5'd0 && (dest == rs || dest == rt);
	endfunction

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	assign isR    = instrD.r.op == OP_SPECIAL;
	assign isAddu = isR && instrD.r.funct == FN_ADDU;
	assign isSubu = isR && instrD.r.funct == FN_SUBU;
	assign isMult = isR && instrD.r.funct == FN_MULT;
	assign isDiv  = isR && instrD.r.funct == FN_DIV;
	assign isMfhi = isR && instrD.r.funct == FN_MFHI;
	assign isMflo = isR && instrD.r.funct == FN_MFLO;
	assign isOri  = instrD.i.op == OP_ORI;
	assign isLui  = instrD.i.op == OP_LUI;
	assign isLw   = instrD.i.op == OP_LW;
	assign isSw   = instrD.i.op == OP_SW;
	assign isBeq  = instrD.i.op == OP_BEQ;
	assign usesRt = isR | isSw | isBeq;

	assign signImm = {{16{instrD.i.imm[15]}}, instrD.i.imm};

	always_comb begin
		ctrl           = '0;
		ctrl.aluOp     = isSubu ? ALU_SUB : (isOri ? ALU_OR : (isLui ? ALU_LUI : ALU_ADD));
		ctrl.immSrc    = isOri | isLui | isLw | isSw;
		ctrl.regWrite  = isAddu | isSubu | isMfhi | isMflo | isOri | isLui | isLw;
		ctrl.dest      = isR ? instrD.r.rd : instrD.i.rt;
		ctrl.memWrite  = isSw;
		ctrl.memToReg  = isLw;
		ctrl.multStart = isMult;
		ctrl.divStart  = isDiv;
		ctrl.selHi     = isMfhi;
		ctrl.selLo     = isMflo;
	end

	// Register file written on the falling edge
	always_ff @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbFwd.regWrite && wbFwd.dest != 5'd0) begin
			regFile[wbFwd.dest] <= wbFwd.data;
		end
	end

	assign rsVal = forwardOperand(instrD.i.rs, regFile[instrD.i.rs], exFwd, wbFwd);
	assign rtVal = forwardOperand(instrD.i.rt, regFile[instrD.i.rt], exFwd, wbFwd);

	////////////////////////////////////////////////////////////
	// Hazards and branch
	////////////////////////////////////////////////////////////
	assign loadUse = idExCur.ctrl.memToReg &&
		hitsSource(idExCur.ctrl.dest, instrD.i.rs, usesRt ? instrD.i.rt : 5'd0);
	assign mduHazard = (isMult | isDiv | isMfhi | isMflo) &&
		(mduBusy || idExCur.ctrl.multStart || idExCur.ctrl.divStart);
	// beq compares here, so a producer in execute or a load in memory must drain first
	assign branchHazard = isBeq &&
		((idExCur.ctrl.regWrite && hitsSource(idExCur.ctrl.dest, instrD.i.rs, instrD.i.rt)) ||
		 (exFwd.ctrl.memToReg && hitsSource(exFwd.ctrl.dest, instrD.i.rs, instrD.i.rt)));

	assign stall        = loadUse | mduHazard | branchHazard;
	assign branchTaken  = isBeq && !stall && rsVal == rtVal;
	assign branchTarget = pcD + 32'd4 + {signImm[29:0], 2'b00};

	always_ff @(posedge clk) begin
		if (reset || stall) begin
			idEx <= '0;    // Bubble
		end else begin
			idEx.pc    <= pcD;
			idEx.ctrl  <= ctrl;
			idEx.rs    <= instrD.i.rs;
			idEx.rt    <= instrD.i.rt;
			idEx.rsVal <= rsVal;
			idEx.rtVal <= rtVal;
			idEx.imm   <= isOri ? {16'h0000, instrD.i.imm} : signImm;
		end
	end

	// No stage may forward a value for r0
	r0ReadsZero: assert property (@(posedge clk) disable iff (reset)
		instrD.i.rs == 5'd0 |-> rsVal == 32'd0);

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic           clk,
	input  logic           reset,
	input  mipsPkg::idExT  idEx,
	input  mipsPkg::exMemT memFwd,
	input  mipsPkg::memWbT wbFwd,
	input  logic [31:0]    hi,
	input  logic [31:0]    lo,
	output logic           mduStart,
	output mipsPkg::mduOpT mduOp,
	output logic [31:0]    mduA,
	output logic [31:0]    mduB,
	output mipsPkg::exMemT exMem
);
	import mipsPkg::*;

	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluB;
	logic [31:0] aluOut;
	logic [31:0] result;

	// Operands again, producers have moved one stage on since decode
	assign opA  = forwardOperand(idEx.rs, idEx.rsVal, memFwd, wbFwd);
	assign opB  = forwardOperand(idEx.rt, idEx.rtVal, memFwd, wbFwd);
	assign aluB = idEx.ctrl.immSrc ? idEx.imm : opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			ALU_ADD: aluOut = opA + aluB;
			ALU_SUB: aluOut = opA - aluB;
			ALU_OR:  aluOut = opA | aluB;
			default: aluOut = {aluB[15:0], 16'h0000};    // lui
		endcase
	end

	assign result = idEx.ctrl.selHi ? hi : (idEx.ctrl.selLo ? lo : aluOut);

	// One-cycle start pulse, each instruction sits here once
	assign mduStart = idEx.ctrl.multStart | idEx.ctrl.divStart;
	assign mduOp    = idEx.ctrl.multStart ? MDU_MULT : (idEx.ctrl.divStart ? MDU_DIV : MDU_NONE);
	assign mduA     = opA;
	assign mduB     = opB;

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem <= '0;
		end else begin
			exMem.pc        <= idEx.pc;
			exMem.ctrl      <= idEx.ctrl;
			exMem.rt        <= idEx.rt;
			exMem.result    <= result;
			exMem.storeData <= opB;
		end
	end

endmodule

/* verilog/mduSequencer.sv */
`timescale 1ns/1ps

module mduSequencer #(
	parameter int MULT_CYCLES = 5,
	parameter int DIV_CYCLES  = 10
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           start,
	input  mipsPkg::mduOpT op,
	input  logic           timerZero,
	output logic           busy,
	output logic           load,
	output logic [4:0]     loadValue,
	output logic           commit
);
	import mipsPkg::*;

	typedef enum logic [1:0] {IDLE, RUN, COMMIT} stateT;

	stateT state;
	stateT stateNext;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			IDLE:    if (start) stateNext = RUN;
			RUN:     if (timerZero) stateNext = COMMIT;
			default: stateNext = IDLE;
		endcase
	end

	assign load      = state == IDLE && start;
	assign loadValue = (op == MDU_DIV) ? 5'(DIV_CYCLES - 1) : 5'(MULT_CYCLES - 1);
	assign busy      = state == RUN;    // Low again while HI/LO update
	assign commit    = state == COMMIT;

	// Decode must hold back mult/div until the unit is free
	noStartWhileBusy: assert property (@(posedge clk) disable iff (reset) busy |-> !start);

endmodule

/* verilog/mduTimer.sv */
`timescale 1ns/1ps

module mduTimer (
	input  logic       clk,
	input  logic       reset,
	input  logic       load,
	input  logic [4:0] loadValue,
	output logic       zero
);

	logic [4:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= loadValue;
		end else if (count != 5'd0) begin
			count <= count - 5'd1;    // Stops at zero
		end
	end

	assign zero = count == 5'd0;

	// Sequencer only reloads once the previous operation has run out
	loadWhenIdle: assert property (@(posedge clk) disable iff (reset) load |-> zero);

endmodule

/* verilog/mduDatapath.sv */
`timescale 1ns/1ps

module mduDatapath (
	input  logic           clk,
	input  logic           reset,
	input  logic           start,
	input  mipsPkg::mduOpT op,
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	input  logic           commit,
	output logic [31:0]    hi,
	output logic [31:0]    lo
);
	import mipsPkg::*;

	mduOpT              opReg;
	logic signed [31:0] aReg;
	logic signed [31:0] bReg;
	logic signed [63:0] product;
	logic signed [31:0] quotient;
	logic signed [31:0] remainder;

	always_ff @(posedge clk) begin
		if (reset) begin
			opReg <= MDU_NONE;
		end else if (start) begin
			opReg <= op;
		end
	end

	// Operand capture
	always_ff @(posedge clk) begin
		if (start) begin
			aReg <= a;
			bReg <= b;
		end
	end

	assign product   = aReg * bReg;
	assign quotient  = aReg / bReg;    // Truncates toward zero
	assign remainder = aReg % bReg;    // Takes sign of dividend

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (commit) begin
			if (opReg == MDU_MULT) begin
				{hi, lo} <= product;
			end else if (opReg == MDU_DIV && bReg != 32'sd0) begin
				lo <= quotient;
				hi <= remainder;
			end
		end
	end

endmodule

/* verilog/memStage.sv */
`timescale 1ns/1ps

module memStage (
	input  logic           clk,
	input  logic           reset,
	input  mipsPkg::exMemT exMem,
	input  logic [31:0]    dataRdata,
	output logic [31:0]    dataAddr,
	output logic [31:0]    dataWdata,
	output logic [3:0]     byteEnable,
	output logic [31:0]    memPc,
	output mipsPkg::memWbT memWb
);

	logic wbHit;

	// Store data from the instruction retiring this cycle
	assign wbHit = memWb.regWrite && memWb.dest != 5'd0 && memWb.dest == exMem.rt;

	assign dataAddr   = exMem.result;
	assign dataWdata  = wbHit ? memWb.data : exMem.storeData;
	assign byteEnable = {4{exMem.ctrl.memWrite}};    // Word stores only
	assign memPc      = exMem.pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			memWb <= '0;
		end else begin
			memWb.pc       <= exMem.pc;
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.dest     <= exMem.ctrl.dest;
			memWb.data     <= exMem.ctrl.memToReg ? dataRdata : exMem.result;
		end
	end

endmodule

/* verilog/mips.sv */
`timescale 1ns/1ps

module mips #(
	parameter logic [31:0] RESET_PC    = 32'h0000_3000,
	parameter int          MULT_CYCLES = 5,
	parameter int          DIV_CYCLES  = 10
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] i_inst_rdata,
	input  logic [31:0] m_data_rdata,
	output logic [31:0] i_inst_addr,
	output logic [31:0] m_data_addr,
	output logic [31:0] m_data_wdata,
	output logic [3:0]  m_data_byteen,
	output logic [31:0] m_inst_addr,
	output logic        w_grf_we,
	output logic [4:0]  w_grf_addr,
	output logic [31:0] w_grf_wdata,
	output logic [31:0] w_inst_addr
);
	import mipsPkg::*;

	logic        stall;
	logic        branchTaken;
	logic [31:0] branchTarget;
	logic [31:0] pcD;
	instrT       instrD;
	idExT        idEx;
	exMemT       exMem;
	memWbT       memWb;

	// Multiply/divide unit
	logic        mduStart;
	mduOpT       mduOp;
	logic [31:0] mduA;
	logic [31:0] mduB;
	logic        mduBusy;
	logic        timerLoad;
	logic [4:0]  timerValue;
	logic        timerZero;
	logic        mduCommit;
	logic [31:0] hi;
	logic [31:0] lo;

	fetchStage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .reset(reset), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.instrIn(i_inst_rdata), .pc(i_inst_addr), .pcD(pcD), .instrD(instrD)
	);

	decodeStage u_decode (
		.clk(clk), .reset(reset), .pcD(pcD), .instrD(instrD),
		.exFwd(exMem), .wbFwd(memWb), .idExCur(idEx), .mduBusy(mduBusy),
		.stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.idEx(idEx)
	);

	executeStage u_execute (
		.clk(clk), .reset(reset), .idEx(idEx), .memFwd(exMem), .wbFwd(memWb),
		.hi(hi), .lo(lo), .mduStart(mduStart), .mduOp(mduOp),
		.mduA(mduA), .mduB(mduB), .exMem(exMem)
	);

	mduSequencer #(.MULT_CYCLES(MULT_CYCLES), .DIV_CYCLES(DIV_CYCLES)) u_mduSeq (
		.clk(clk), .reset(reset), .start(mduStart), .op(mduOp),
		.timerZero(timerZero), .busy(mduBusy), .load(timerLoad),
		.loadValue(timerValue), .commit(mduCommit)
	);

	mduTimer u_mduTimer (
		.clk(clk), .reset(reset), .load(timerLoad), .loadValue(timerValue),
		.zero(timerZero)
	);

	mduDatapath u_mduData (
		.clk(clk), .reset(reset), .start(mduStart), .op(mduOp),
		.a(mduA), .b(mduB), .commit(mduCommit), .hi(hi), .lo(lo)
	);

	memStage u_mem (
		.clk(clk), .reset(reset), .exMem(exMem), .dataRdata(m_data_rdata),
		.dataAddr(m_data_addr), .dataWdata(m_data_wdata),
		.byteEnable(m_data_byteen), .memPc(m_inst_addr), .memWb(memWb)
	);

	// Retirement trace
	assign w_grf_we    = memWb.regWrite;
	assign w_grf_addr  = memWb.dest;
	assign w_grf_wdata = memWb.data;
	assign w_inst_addr = memWb.pc;

endmodule

/* testbench/tbMips.sv */
`timescale 1ns/1ps

module tbMips;

	localparam logic [31:0] RESET_PC     = 32'h0000_3000;
	localparam int          MULT_CYCLES  = 5;
	localparam int          DIV_CYCLES   = 10;
	localparam int          PERIOD       = 20;
	localparam int          RESET_CYCLES = 8;

	// MIPS store word opcode
	localparam logic [5:0]  SW_OPCODE    = 6'h2b;

	// Word offsets of the sections in the stimulus file
	localparam int PROG_BASE   = 'h10;
	localparam int DATA_BASE   = 'h40;
	localparam int RETIRE_BASE = 'h50;
	localparam int STORE_BASE  = 'hA0;

	logic        clk;
	logic        reset;
	logic [31:0] instAddr;
	logic [31:0] instRdata;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic [31:0] dataRdata;
	logic [3:0]  byteEn;
	logic [31:0] memPc;
	logic        grfWe;
	logic [4:0]  grfAddr;
	logic [31:0] grfWdata;
	logic [31:0] retirePc;

	logic [31:0] stim [256];
	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	int          progCount;
	int          dataCount;
	int          retireCount;
	int          storeCount;
	int          retireIdx;
	int          storeIdx;

	mips #(.RESET_PC(RESET_PC), .MULT_CYCLES(MULT_CYCLES), .DIV_CYCLES(DIV_CYCLES)) i_mips (
		.clk(clk), .reset(reset), .i_inst_rdata(instRdata), .m_data_rdata(dataRdata),
		.i_inst_addr(instAddr), .m_data_addr(dataAddr), .m_data_wdata(dataWdata),
		.m_data_byteen(byteEn), .m_inst_addr(memPc), .w_grf_we(grfWe),
		.w_grf_addr(grfAddr), .w_grf_wdata(grfWdata), .w_inst_addr(retirePc)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// Words past the program read as nop
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - RESET_PC;
		if (addr < RESET_PC || offset[31:2] >= 30'd64) begin
			return 32'h0000_0000;
		end
		return imem[offset[7:2]];
	endfunction

	task automatic loadStimulus();
		for (int i = 0; i < 256; i++) begin
			stim[i] = '0;
		end
		$readmemh("testbench/mipsStimulus.dat", stim);
		progCount   = int'(stim[0]);
		dataCount   = int'(stim[1]);
		retireCount = int'(stim[2]);
		storeCount  = int'(stim[3]);
		if (progCount == 0 || progCount > 48 || dataCount > 16 || retireCount > 26 ||
				storeCount > 48) begin
			failRun("stimulus file is missing or its section counts are out of range");
		end else begin
			for (int i = 0; i < 64; i++) begin
				imem[i] = (i < progCount) ? stim[PROG_BASE + i] : 32'h0000_0000;
				dmem[i] = (i < dataCount) ? stim[DATA_BASE + i] : 32'hDEAD_0000 + 32'(i * 4);
			end
		end
	endtask

	task automatic compareRetirement();
		int base;
		if (retireIdx >= retireCount) begin
			failRun($sformatf("register r%0d written by pc %h after the last expected retirement",
				grfAddr, retirePc));
		end else begin
			base = RETIRE_BASE + 3 * retireIdx;
			checkValue($sformatf("retire %0d pc", retireIdx), stim[base], retirePc);
			checkValue($sformatf("retire %0d reg", retireIdx), stim[base + 1], {27'd0, grfAddr});
			checkValue($sformatf("retire %0d data", retireIdx), stim[base + 2], grfWdata);
			retireIdx++;
		end
	endtask

	task automatic compareStore();
		int          base;
		logic [31:0] storeInstr;
		if (storeIdx >= storeCount) begin
			failRun($sformatf("store to address %h after the last expected store", dataAddr));
		end else begin
			base       = STORE_BASE + 2 * storeIdx;
			storeInstr = fetchWord(memPc);
			checkValue($sformatf("store %0d byteen", storeIdx), 32'h0000_000F, {28'd0, byteEn});
			checkValue($sformatf("store %0d addr", storeIdx), stim[base], dataAddr);
			checkValue($sformatf("store %0d data", storeIdx), stim[base + 1], dataWdata);
			// m_inst_addr points at the sw itself
			checkValue($sformatf("store %0d pc opcode", storeIdx), {26'd0, SW_OPCODE},
				{26'd0, storeInstr[31:26]});
			dmem[dataAddr[7:2]] = dataWdata;
			storeIdx++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Clock, reset and memories
	////////////////////////////////////////////////////////////
	always #(PERIOD / 2) clk = ~clk;

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		instRdata = '0;
		dataRdata = '0;
		retireIdx = 0;
		storeIdx  = 0;
		loadStimulus();
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0;
	end

	// Both memories answer in the same cycle
	always @(posedge clk) begin
		#2;
		instRdata <= fetchWord(instAddr);
		dataRdata <= dmem[dataAddr[7:2]];
	end

	// Outputs idle through reset and one cycle past it
	initial begin
		@(posedge clk);
		do begin
			@(negedge clk);
			checkValue("reset i_inst_addr", RESET_PC, instAddr);
			checkValue("reset w_grf_we", 32'd0, {31'd0, grfWe});
			checkValue("reset m_data_byteen", 32'd0, {28'd0, byteEn});
		end while (reset);
	end

	////////////////////////////////////////////////////////////
	// Trace checker and watchdog
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!reset) begin
			if (grfWe) begin
				compareRetirement();
			end
			if (byteEn != 4'b0000) begin
				compareStore();    // Also updates the data memory
			end
			if (retireIdx == retireCount && storeIdx == storeCount) begin
				$display("TESTS PASSED");
				$finish;
			end
		end
	end

	initial begin
		@(negedge reset);
		#(progCount * (DIV_CYCLES + 6) * PERIOD);
		failRun($sformatf(
			"program did not finish, %0d of %0d retirements and %0d of %0d stores seen",
			retireIdx, retireCount, storeIdx, storeCount));
	end

endmodule

/* testbench/mipsStimulus.dat */
// @000 counts: program words, data words, retire entries, store entries
// @010 program, @040 data, @050 retire trace (pc reg value), @0A0 store trace (addr data)
@000
00000020 00000002 00000016 00000003
@010
// ori, lui, addu, subu / ori, addu, sw, lw
34010005 3C021234 00221821 00612023
348500FF 00A33021 AC060008 8C070008
// addu after load, lw, ori, mult / mfhi, mflo, ori, div
00E14021 8C090004 340A0003 012A0018
00005810 00006012 340D0064 01A9001A
// mfhi, mflo, div by zero, mfhi / mflo, beq not taken, slot, ori
00007010 00007812 01A0001A 00008010
00008812 10240004 34120011 34130022
// beq taken, slot, two skipped / target addu, sw, lw, sw
12730003 0272A021 34150BAD 34160BAD
0281B821 AC17000C 8C18000C AC180010
@040
11112222 FFFFFFF9
@050
00003000 00000001 00000005
00003004 00000002 12340000
00003008 00000003 12340005
0000300C 00000004 12340000
00003010 00000005 123400FF
00003014 00000006 24680104
0000301C 00000007 24680104
00003020 00000008 24680109
00003024 00000009 FFFFFFF9
00003028 0000000A 00000003
00003030 0000000B FFFFFFFF
00003034 0000000C FFFFFFEB
00003038 0000000D 00000064
00003040 0000000E 00000002
00003044 0000000F FFFFFFF2
0000304C 00000010 00000002
00003050 00000011 FFFFFFF2
00003058 00000012 00000011
0000305C 00000013 00000022
00003064 00000014 00000033
00003070 00000017 00000038
00003078 00000018 00000038
@0A0
00000008 24680104
0000000C 00000038
00000010 00000038

/* src.f */
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/mduSequencer.sv
verilog/mduTimer.sv
verilog/mduDatapath.sv
verilog/memStage.sv
verilog/mips.sv
testbench/tbMips.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbMips
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES   := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)
STIMULUS  := testbench/mipsStimulus.dat
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(STIMULUS)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
